/* all.f */
hdl/tmr_pkg.sv
hdl/tmr_cfg_if.sv
hdl/tmr_wb_regs.sv
hdl/tmr_lockstep_fsm.sv
hdl/tmr_majority_voter.sv
hdl/tmr_ctrl_top.sv
testbench/tb_tmr_ctrl.sv

/* hdl/tmr_cfg_if.sv */
`timescale 1ns/1ps

interface tmr_cfg_if;

  // Register file to state machine
  logic                       enable;
  tmr_pkg::tmr_cfg_word_u     cfg;
  logic [tmr_pkg::DATA_W-1:0] sp_store;
  logic                       sp_store_zero_wr;
  tmr_pkg::tmr_mode_e         mode_status;

  // State machine to register file
  logic                       force_clear;
  logic [2:0]                 incr_mismatch;
  tmr_pkg::tmr_mode_e         mode;

  // Current mode as seen by the register file for STATUS reads
  assign mode_status = mode;

  modport regs (
    output enable, cfg, sp_store, sp_store_zero_wr,
    input  mode_status, force_clear, incr_mismatch
  );

  modport fsm (
    input  enable, cfg, sp_store, sp_store_zero_wr,
    output force_clear, incr_mismatch, mode
  );

endinterface

/* hdl/tmr_ctrl_top.sv */
`timescale 1ns/1ps

module tmr_ctrl_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [7:0]                 wb_adr_i,
  input  logic [tmr_pkg::DATA_W-1:0] wb_dat_i,
  output logic [tmr_pkg::DATA_W-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  input  logic [tmr_pkg::DATA_W-1:0] core_a_i,
  input  logic [tmr_pkg::DATA_W-1:0] core_b_i,
  input  logic [tmr_pkg::DATA_W-1:0] core_c_i,
  output logic [tmr_pkg::DATA_W-1:0] voted_o,
  input  logic                       fetch_en_i,
  input  logic                       cores_synch_i,
  output logic                       setback_o,
  output logic                       resynch_req_o,
  output logic                       grp_independent_o,
  output logic                       rapid_recovery_en_o
);

  logic [2:0] error;
  logic       single_mismatch;
  logic       failure;

  tmr_cfg_if u_cfg_if ();

  tmr_wb_regs u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg      (u_cfg_if.regs)
  );

  tmr_majority_voter u_voter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .core_a_i          (core_a_i),
    .core_b_i          (core_b_i),
    .core_c_i          (core_c_i),
    .voted_o           (voted_o),
    .error_o           (error),
    .single_mismatch_o (single_mismatch),
    .failure_o         (failure)
  );

  tmr_lockstep_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .cfg                 (u_cfg_if.fsm),
    .single_mismatch_i   (single_mismatch),
    .failure_i           (failure),
    .error_i             (error),
    .fetch_en_i          (fetch_en_i),
    .cores_synch_i       (cores_synch_i),
    .setback_o           (setback_o),
    .resynch_req_o       (resynch_req_o),
    .grp_independent_o   (grp_independent_o),
    .rapid_recovery_en_o (rapid_recovery_en_o)
  );

endmodule

/* hdl/tmr_lockstep_fsm.sv */
`timescale 1ns/1ps

module tmr_lockstep_fsm (
  input  logic       clk_i,
  input  logic       rst_ni,
  tmr_cfg_if.fsm     cfg,
  input  logic       single_mismatch_i,
  input  logic       failure_i,
  input  logic [2:0] error_i,
  input  logic       fetch_en_i,
  input  logic       cores_synch_i,
  output logic       setback_o,
  output logic       resynch_req_o,
  output logic       grp_independent_o,
  output logic       rapid_recovery_en_o
);

  tmr_pkg::tmr_mode_e mode_d;
  tmr_pkg::tmr_mode_e mode_q;
  logic               setback_d;
  logic               setback_q;
  logic               delay;
  logic               sb_en;

  assign delay = cfg.cfg.fields.delay_resynch;
  assign sb_en = cfg.cfg.fields.setback;

  always_comb begin
    mode_d            = mode_q;
    setback_d         = 1'b0;
    cfg.force_clear   = 1'b0;
    cfg.incr_mismatch = '0;

    case (mode_q)
      tmr_pkg::TMR_RUN: begin
        cfg.force_clear = cfg.cfg.fields.force_resynch;
        if (cfg.cfg.fields.force_resynch || single_mismatch_i) begin
          cfg.incr_mismatch = error_i;
          if (!delay) begin
            mode_d = tmr_pkg::TMR_UNLOAD;
          end
        end
      end
      tmr_pkg::TMR_UNLOAD: begin
        // Software stored its state, cores can be reset and reloaded
        if (cfg.sp_store != '0) begin
          mode_d    = tmr_pkg::TMR_RELOAD;
          setback_d = sb_en;
        end
      end
      tmr_pkg::TMR_RELOAD: begin
        if (cfg.sp_store == '0) begin
          mode_d = tmr_pkg::TMR_RUN;
        end else if ((single_mismatch_i || failure_i) && sb_en &&
                     cfg.cfg.fields.reload_setback && !cfg.sp_store_zero_wr) begin
          // Disagreement during reload restarts the cores again
          setback_d = 1'b1;
        end
      end
      default: begin
      end
    endcase

    // Before fetch starts the enable bit alone picks the mode
    if (!fetch_en_i) begin
      mode_d = cfg.enable ? tmr_pkg::TMR_RUN : tmr_pkg::NON_TMR;
    end
    if (mode_q == tmr_pkg::TMR_RUN && !cfg.enable) begin
      mode_d = tmr_pkg::NON_TMR;
    end
    // Rejoin only once the cores report matching state
    if (mode_q == tmr_pkg::NON_TMR && cores_synch_i && cfg.enable) begin
      mode_d = tmr_pkg::TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= tmr_pkg::NON_TMR;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign cfg.mode            = mode_q;
  assign setback_o           = setback_q;
  assign resynch_req_o       = mode_q == tmr_pkg::TMR_UNLOAD;
  assign grp_independent_o   = mode_q == tmr_pkg::NON_TMR;
  assign rapid_recovery_en_o = cfg.cfg.fields.rapid_recovery && tmr_pkg::RAPID_RECOVERY_EN;

endmodule

/* hdl/tmr_majority_voter.sv */
`timescale 1ns/1ps

module tmr_majority_voter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [tmr_pkg::DATA_W-1:0] core_a_i,
  input  logic [tmr_pkg::DATA_W-1:0] core_b_i,
  input  logic [tmr_pkg::DATA_W-1:0] core_c_i,
  output logic [tmr_pkg::DATA_W-1:0] voted_o,
  output logic [2:0]                 error_o,
  output logic                       single_mismatch_o,
  output logic                       failure_o
);

  logic [tmr_pkg::DATA_W-1:0] maj;
  logic [2:0]                 err;
  logic                       single;
  logic                       fail;

  logic [tmr_pkg::DATA_W-1:0] voted_q;
  logic [2:0]                 error_q;
  logic                       single_q;
  logic                       failure_q;

  // Each bit takes the value held by at least two cores
  assign maj = (core_a_i & core_b_i) | (core_a_i & core_c_i) | (core_b_i & core_c_i);

  assign err[0] = core_a_i != maj;
  assign err[1] = core_b_i != maj;
  assign err[2] = core_c_i != maj;

  always_comb begin
    single = 1'b0;
    case (err)
      3'b001, 3'b010, 3'b100: single = 1'b1;
      default:                single = 1'b0;
    endcase
  end

  // Two cores off the vote, no core can be trusted as reference
  assign fail = (err[0] & err[1]) | (err[0] & err[2]) | (err[1] & err[2]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      voted_q   <= '0;
      error_q   <= '0;
      single_q  <= 1'b0;
      failure_q <= 1'b0;
    end else begin
      voted_q   <= maj;
      error_q   <= err;
      single_q  <= single;
      failure_q <= fail;
    end
  end

  assign voted_o           = voted_q;
  assign error_o           = error_q;
  assign single_mismatch_o = single_q;
  assign failure_o         = failure_q;

endmodule

/* hdl/tmr_pkg.sv */
package tmr_pkg;

  // Bus and datapath widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned CNT_W  = 16;

  // Rapid recovery is built in for this group
  localparam bit RAPID_RECOVERY_EN = 1'b1;

  // Register byte addresses
  localparam logic [7:0] ADDR_ENABLE   = 8'h00;
  localparam logic [7:0] ADDR_CONFIG   = 8'h04;
  localparam logic [7:0] ADDR_SP_STORE = 8'h08;
  localparam logic [7:0] ADDR_STATUS   = 8'h0C;
  localparam logic [7:0] ADDR_CNT0     = 8'h10;
  localparam logic [7:0] ADDR_CNT1     = 8'h14;
  localparam logic [7:0] ADDR_CNT2     = 8'h18;

  // Redundancy mode of the core group
  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } tmr_mode_e;

  // CONFIG register layout, LSB first from delay_resynch
  typedef struct packed {
    logic [DATA_W-6:0] reserved;
    logic              force_resynch;
    logic              rapid_recovery;
    logic              reload_setback;
    logic              setback;
    logic              delay_resynch;
  } tmr_cfg_fields_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    tmr_cfg_fields_t   fields;
  } tmr_cfg_word_u;

endpackage

/* hdl/tmr_wb_regs.sv */
`timescale 1ns/1ps

module tmr_wb_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [7:0]                 wb_adr_i,
  input  logic [tmr_pkg::DATA_W-1:0] wb_dat_i,
  output logic [tmr_pkg::DATA_W-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  tmr_cfg_if.regs                    cfg
);

  logic                       ack_q;
  logic                       access;
  logic                       wr;
  logic                       enable_q;
  tmr_pkg::tmr_cfg_word_u     cfg_q;
  tmr_pkg::tmr_cfg_word_u     wdata;
  logic [tmr_pkg::DATA_W-1:0] sp_store_q;
  logic [tmr_pkg::DATA_W-1:0] rdata;
  logic [tmr_pkg::DATA_W-1:0] dat_q;
  logic [tmr_pkg::CNT_W-1:0]  cnt_q [3];

  // Ack blocks a second access in the cycle after it
  assign access = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr     = access && wb_we_i;
  assign wdata  = wb_dat_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      dat_q      <= '0;
      enable_q   <= 1'b0;
      cfg_q      <= '0;
      sp_store_q <= '0;
    end else begin
      ack_q <= access;
      if (access) begin
        dat_q <= rdata;
      end
      if (wr && wb_adr_i == tmr_pkg::ADDR_ENABLE) begin
        enable_q <= wdata.raw[0];
      end
      if (wr && wb_adr_i == tmr_pkg::ADDR_SP_STORE) begin
        sp_store_q <= wdata.raw;
      end
      // A bus write to CONFIG takes precedence over the self-clear
      if (wr && wb_adr_i == tmr_pkg::ADDR_CONFIG) begin
        cfg_q.fields.delay_resynch  <= wdata.fields.delay_resynch;
        cfg_q.fields.setback        <= wdata.fields.setback;
        cfg_q.fields.reload_setback <= wdata.fields.reload_setback;
        cfg_q.fields.rapid_recovery <= wdata.fields.rapid_recovery;
        cfg_q.fields.force_resynch  <= wdata.fields.force_resynch;
      end else if (cfg.force_clear) begin
        cfg_q.fields.force_resynch <= 1'b0;
      end
    end
  end

  // Saturating mismatch counters that a write to their own address clears
  for (genvar k = 0; k < 3; k++) begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[k] <= '0;
      end else if (wr && wb_adr_i == tmr_pkg::ADDR_CNT0 + 8'(4 * k)) begin
        cnt_q[k] <= '0;
      end else if (cfg.incr_mismatch[k] && cnt_q[k] != '1) begin
        cnt_q[k] <= cnt_q[k] + 1'b1;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      tmr_pkg::ADDR_ENABLE:   rdata[0] = enable_q;
      tmr_pkg::ADDR_CONFIG:   rdata = cfg_q.raw;
      tmr_pkg::ADDR_SP_STORE: rdata = sp_store_q;
      tmr_pkg::ADDR_STATUS:   rdata[1:0] = cfg.mode_status;
      tmr_pkg::ADDR_CNT0:     rdata[tmr_pkg::CNT_W-1:0] = cnt_q[0];
      tmr_pkg::ADDR_CNT1:     rdata[tmr_pkg::CNT_W-1:0] = cnt_q[1];
      tmr_pkg::ADDR_CNT2:     rdata[tmr_pkg::CNT_W-1:0] = cnt_q[2];
      default:                rdata = '0;
    endcase
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  assign cfg.enable           = enable_q;
  assign cfg.cfg              = cfg_q;
  assign cfg.sp_store         = sp_store_q;
  assign cfg.sp_store_zero_wr = wr && wb_adr_i == tmr_pkg::ADDR_SP_STORE && wb_dat_i == '0;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps --top-module tb_tmr_ctrl \
    -Mdir obj_dir -f all.f &&
  ./obj_dir/Vtb_tmr_ctrl | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null ||
  { echo "Simulation did not pass"; exit 1; }

/* testbench/tb_tmr_ctrl.sv */
`timescale 1ns/1ps

module tb_tmr_ctrl;

  localparam int CLK_PERIOD  = 40;
  localparam int WATCHDOG_NS = 6 * 200 * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [31:0] core_a;
  logic [31:0] core_b;
  logic [31:0] core_c;
  logic [31:0] voted;
  logic        fetch_en;
  logic        cores_synch;
  logic        setback;
  logic        resynch_req;
  logic        grp_independent;
  logic        rapid_recovery_en;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     setback_pulses;

  tmr_ctrl_top UUT (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .wb_cyc_i            (wb_cyc),
    .wb_stb_i            (wb_stb),
    .wb_we_i             (wb_we),
    .wb_adr_i            (wb_adr),
    .wb_dat_i            (wb_dat_w),
    .wb_dat_o            (wb_dat_r),
    .wb_ack_o            (wb_ack),
    .core_a_i            (core_a),
    .core_b_i            (core_b),
    .core_c_i            (core_c),
    .voted_o             (voted),
    .fetch_en_i          (fetch_en),
    .cores_synch_i       (cores_synch),
    .setback_o           (setback),
    .resynch_req_o       (resynch_req),
    .grp_independent_o   (grp_independent),
    .rapid_recovery_en_o (rapid_recovery_en)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Counts clock cycles with setback high
  always @(posedge clk) begin
    if (setback) begin
      setback_pulses <= setback_pulses + 1;
    end
  end

  function automatic logic [31:0] bit_majority(input logic [31:0] a, input logic [31:0] b,
                                               input logic [31:0] c);
    logic [31:0] res;
    int          ones;
    for (int i = 0; i < 32; i++) begin
      ones   = int'(a[i]) + int'(b[i]) + int'(c[i]);
      res[i] = (ones >= 2);
    end
    return res;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_for_ack(input string kind, input logic [7:0] adr);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 10);
    if (!wb_ack) begin
      $display("The register file never acknowledged the %s of address %h", kind, adr);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wait_for_ack("write", adr);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_for_ack("read", adr);
    dat    = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic expect_mode(input tmr_pkg::tmr_mode_e mode);
    logic [31:0] rd;
    wb_read(tmr_pkg::ADDR_STATUS, rd);
    check_word("STATUS", rd, 32'(mode));
  endtask

  task automatic set_cores(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    core_a = a;
    core_b = b;
    core_c = c;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  task automatic test_reset_and_readback();
    logic [31:0] rd;
    logic [31:0] r;
    int          errs;
    errs = errors;
    check_bit("setback_o", setback, 1'b0);
    check_bit("resynch_req_o", resynch_req, 1'b0);
    check_bit("rapid_recovery_en_o", rapid_recovery_en, 1'b0);
    check_bit("wb_ack_o", wb_ack, 1'b0);
    check_bit("grp_independent_o", grp_independent, 1'b1);
    check_word("voted_o", voted, 32'h0);
    for (int a = 0; a < 28; a += 4) begin
      wb_read(8'(a), rd);
      check_word($sformatf("register %h after reset", a), rd, 32'h0);
    end
    wb_write(tmr_pkg::ADDR_ENABLE, 32'h1);
    wb_read(tmr_pkg::ADDR_ENABLE, rd);
    check_word("ENABLE", rd, 32'h1);
    wb_write(tmr_pkg::ADDR_ENABLE, 32'h0);
    wb_write(tmr_pkg::ADDR_CONFIG, 32'hffff_ffff);
    wb_read(tmr_pkg::ADDR_CONFIG, rd);
    // Only the five field bits exist, force_resynch is ignored here
    check_word("CONFIG", rd & 32'hffff_ffef, 32'h0000_000f);
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h0);
    r = $random(seed);
    wb_write(tmr_pkg::ADDR_SP_STORE, r);
    wb_read(tmr_pkg::ADDR_SP_STORE, rd);
    check_word("SP_STORE", rd, r);
    wb_write(tmr_pkg::ADDR_SP_STORE, 32'h0);
    wb_write(8'h20, 32'hffff_ffff);
    wb_read(8'h20, rd);
    check_word("unmapped address 20", rd, 32'h0);
    report_test("reset values and readback", errs);
  endtask

  task automatic test_mode_switching();
    int errs;
    errs = errors;
    wb_write(tmr_pkg::ADDR_ENABLE, 32'h1);
    expect_mode(tmr_pkg::TMR_RUN);
    check_bit("grp_independent_o", grp_independent, 1'b0);
    wb_write(tmr_pkg::ADDR_ENABLE, 32'h0);
    expect_mode(tmr_pkg::NON_TMR);
    check_bit("grp_independent_o", grp_independent, 1'b1);
    fetch_en = 1'b1;
    wb_write(tmr_pkg::ADDR_ENABLE, 32'h1);
    expect_mode(tmr_pkg::NON_TMR);
    cores_synch = 1'b1;
    @(negedge clk);
    cores_synch = 1'b0;
    expect_mode(tmr_pkg::TMR_RUN);
    check_bit("grp_independent_o", grp_independent, 1'b0);
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h8);
    check_bit("rapid_recovery_en_o", rapid_recovery_en, 1'b1);
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h0);
    check_bit("rapid_recovery_en_o", rapid_recovery_en, 1'b0);
    report_test("mode switching", errs);
  endtask

  task automatic test_mismatch_unload();
    logic [31:0] r;
    logic [31:0] rd;
    int          errs;
    errs = errors;
    r = $random(seed);
    set_cores(r, r, r);
    repeat (2) @(negedge clk);
    core_b = r ^ 32'h0000_0100;
    @(negedge clk);
    check_word("voted_o", voted, core_a);
    check_bit("resynch_req_o after 1 cycle", resynch_req, 1'b0);
    @(negedge clk);
    check_bit("resynch_req_o after 2 cycles", resynch_req, 1'b1);
    core_b = r;
    expect_mode(tmr_pkg::TMR_UNLOAD);
    wb_read(tmr_pkg::ADDR_CNT0, rd);
    check_word("CNT0", rd, 32'h0);
    wb_read(tmr_pkg::ADDR_CNT1, rd);
    check_word("CNT1", rd, 32'h1);
    wb_read(tmr_pkg::ADDR_CNT2, rd);
    check_word("CNT2", rd, 32'h0);
    wb_write(tmr_pkg::ADDR_CNT1, 32'h0);
    wb_read(tmr_pkg::ADDR_CNT1, rd);
    check_word("CNT1 after clear", rd, 32'h0);
    report_test("single mismatch and unload", errs);
  endtask

  task automatic test_reload_setback();
    logic [31:0] r;
    int          base;
    int          errs;
    errs = errors;
    r    = core_a;
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h6);
    base = setback_pulses;
    wb_write(tmr_pkg::ADDR_SP_STORE, $random(seed) | 32'h1);
    repeat (3) @(negedge clk);
    check_word("setback pulses on reload", 32'(setback_pulses - base), 32'd1);
    expect_mode(tmr_pkg::TMR_RELOAD);
    base = setback_pulses;
    set_cores(r, r ^ 32'h1, r ^ 32'h2);
    @(negedge clk);
    set_cores(r, r, r);
    repeat (3) @(negedge clk);
    check_word("setback pulses on failure", 32'(setback_pulses - base), 32'd1);
    wb_write(tmr_pkg::ADDR_SP_STORE, 32'h0);
    expect_mode(tmr_pkg::TMR_RUN);
    report_test("reload and setback", errs);
  endtask

  task automatic test_force_and_delay();
    logic [31:0] rd;
    int          errs;
    errs = errors;
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h10);
    expect_mode(tmr_pkg::TMR_UNLOAD);
    wb_read(tmr_pkg::ADDR_CONFIG, rd);
    check_word("CONFIG after force", rd, 32'h0);
    wb_write(tmr_pkg::ADDR_SP_STORE, 32'h5);
    wb_write(tmr_pkg::ADDR_SP_STORE, 32'h0);
    expect_mode(tmr_pkg::TMR_RUN);
    wb_write(tmr_pkg::ADDR_CONFIG, 32'h1);
    core_c = ~core_a;
    @(negedge clk);
    core_c = core_a;
    repeat (2) @(negedge clk);
    expect_mode(tmr_pkg::TMR_RUN);
    wb_read(tmr_pkg::ADDR_CNT2, rd);
    check_word("CNT2 with delayed resync", rd, 32'h1);
    report_test("forced and delayed resync", errs);
  endtask

  task automatic test_random_votes();
    logic [31:0] r;
    logic [31:0] bad;
    int          errs;
    errs = errors;
    for (int i = 0; i < 18; i++) begin
      r   = $random(seed);
      bad = $random(seed);
      case (i % 3)
        0:       set_cores(bad, r, r);
        1:       set_cores(r, bad, r);
        default: set_cores(r, r, bad);
      endcase
      @(negedge clk);
      check_word("voted_o", voted, bit_majority(core_a, core_b, core_c));
    end
    set_cores(r, r, r);
    report_test("random majority votes", errs);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    seed           = 32'hd81d_b4cc;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    setback_pulses = 0;
    clk            = 1'b0;
    rst_n          = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = 8'h0;
    wb_dat_w       = 32'h0;
    set_cores(32'h0, 32'h0, 32'h0);
    fetch_en       = 1'b0;
    cores_synch    = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_and_readback();
    test_mode_switching();
    test_mismatch_unload();
    test_reload_setback();
    test_force_and_delay();
    test_random_votes();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
